//--- spw_link_pkg.sv
// Link state enum, receive event bit positions and event count
package spw_link_pkg;

  // ----------------------------------------
  // Link states
  // ----------------------------------------

  // Connection states of the link, walked in this order on the way up
  // ERROR_RESET holds the transmitter and receiver in reset
  // RUN is the only state where data characters flow
  typedef enum logic [2:0] {
    ERROR_RESET = 3'd0,
    ERROR_WAIT  = 3'd1,
    READY       = 3'd2,
    STARTED     = 3'd3,
    CONNECTING  = 3'd4,
    RUN         = 3'd5
  } link_state_t;

  // ----------------------------------------
  // Receive events
  // ----------------------------------------

  // Number of receive events carried from the receiver
  localparam int NUM_EVENTS = 5;

  // Bit positions inside the receive event vector
  localparam int EV_NULL      = 0;
  localparam int EV_FCT       = 1;
  localparam int EV_N_CHAR    = 2;
  localparam int EV_TIME_CODE = 3;
  // Disconnect, parity or escape error reported by the receiver
  localparam int EV_RX_ERROR  = 4;

endpackage

//--- spw_timing_pkg.sv
// Delay counter type and default short and long delay tick counts
package spw_timing_pkg;

  // Width of the delay counter in system clock ticks
  typedef logic [15:0] tick_count_t;

  // Nominal 6.4 us at a 100 MHz system clock
  localparam tick_count_t DEFAULT_TICKS_SHORT = 16'd640;

  // Nominal 12.8 us at a 100 MHz system clock
  localparam tick_count_t DEFAULT_TICKS_LONG  = 16'd1280;

  // Both values scale with the system clock frequency
  // A different clock only needs new module parameters on the top level

endpackage

//--- spw_rx_event_if.sv
// Interface spw_rx_event_if with the five receive event strobes and its modports
`timescale 1ns/1ns

interface spw_rx_event_if;

  // One system clock pulse per received NULL
  logic got_null;
  // One system clock pulse per received FCT
  logic got_fct;
  // One system clock pulse per received data character or EOP
  logic got_n_char;
  // One system clock pulse per received time code
  logic got_time_code;
  // One system clock pulse per receive error
  logic rx_error;

  // The synchronizer produces the strobes
  modport source (
    output got_null, got_fct, got_n_char, got_time_code, rx_error
  );

  // The link state machine consumes the strobes
  modport sink (
    input got_null, got_fct, got_n_char, got_time_code, rx_error
  );

endinterface

//--- spw_rx_event_sync.sv
// Module spw_rx_event_sync, toggle crossing of receive events into the system clock
`timescale 1ns/1ns

module spw_rx_event_sync (
  input  logic                                i_clk,
  input  logic                                i_rx_clk,
  input  logic                                i_reset,
  input  logic [spw_link_pkg::NUM_EVENTS-1:0] i_rx_events,
  spw_rx_event_if.source                      ev
);

  // Event pulses in the system clock domain, one bit per event kind
  logic [spw_link_pkg::NUM_EVENTS-1:0] ev_pulse;

  // ----------------------------------------
  // Per event crossing
  // ----------------------------------------

  // Each event becomes a level change in the receive domain
  // The level change crosses safely and is turned back into a pulse
  for (genvar g = 0; g < spw_link_pkg::NUM_EVENTS; g++)
  begin : g_event
    logic rx_toggle;
    logic sync_meta;
    logic sync_stable;
    logic sync_prev;

    // Toggle flip-flop in the receive clock domain
    always_ff @(posedge i_rx_clk or posedge i_reset)
    begin
      if (i_reset)
        rx_toggle <= 1'b0;
      else if (i_rx_events[g])
        rx_toggle <= ~rx_toggle;
    end

    // Two flop synchronizer plus one history flop for the edge detector
    always_ff @(posedge i_clk or posedge i_reset)
    begin
      if (i_reset)
      begin
        sync_meta   <= 1'b0;
        sync_stable <= 1'b0;
        sync_prev   <= 1'b0;
      end
      else
      begin
        sync_meta   <= rx_toggle;
        sync_stable <= sync_meta;
        sync_prev   <= sync_stable;
      end
    end

    // Any change of the synchronized level is one event
    assign ev_pulse[g] = sync_stable ^ sync_prev;
  end

  // ----------------------------------------
  // Map vector bits onto the interface
  // ----------------------------------------
  assign ev.got_null      = ev_pulse[spw_link_pkg::EV_NULL];
  assign ev.got_fct       = ev_pulse[spw_link_pkg::EV_FCT];
  assign ev.got_n_char    = ev_pulse[spw_link_pkg::EV_N_CHAR];
  assign ev.got_time_code = ev_pulse[spw_link_pkg::EV_TIME_CODE];
  assign ev.rx_error      = ev_pulse[spw_link_pkg::EV_RX_ERROR];

endmodule

//--- spw_link_timer.sv
// Module spw_link_timer, restartable delay counter with short and long expiry levels
`timescale 1ns/1ns

module spw_link_timer #(
  parameter spw_timing_pkg::tick_count_t TICKS_SHORT = spw_timing_pkg::DEFAULT_TICKS_SHORT,
  parameter spw_timing_pkg::tick_count_t TICKS_LONG  = spw_timing_pkg::DEFAULT_TICKS_LONG
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_restart,
  output logic o_after_short,
  output logic o_after_long
);

  // Ticks elapsed since the last restart or reset
  spw_timing_pkg::tick_count_t count;
  spw_timing_pkg::tick_count_t count_next;

  // Restart wins over counting
  // The count stops at the long delay so it never wraps back to zero
  always_comb
  begin
    if (i_restart)
      count_next = '0;
    else if (count >= TICKS_LONG)
      count_next = count;
    else
      count_next = count + 16'd1;
  end

  // Expiry levels are compared on the next count and registered
  // so they change on the same edge as the count itself
  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      count         <= '0;
      o_after_short <= 1'b0;
      o_after_long  <= 1'b0;
    end
    else
    begin
      count         <= count_next;
      o_after_short <= (count_next >= TICKS_SHORT);
      o_after_long  <= (count_next >= TICKS_LONG);
    end
  end

endmodule

//--- spw_link_fsm.sv
// Module spw_link_fsm, link state machine with output decode and event pulses
`timescale 1ns/1ns

module spw_link_fsm (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_link_start,
  input  logic                      i_link_disable,
  input  logic                      i_auto_start,
  spw_rx_event_if.sink              ev,
  input  logic                      i_after_short,
  input  logic                      i_after_long,
  output logic                      o_timer_restart,
  output spw_link_pkg::link_state_t o_link_state,
  output logic                      o_tx_en,
  output logic                      o_rx_en,
  output logic                      o_send_nulls,
  output logic                      o_send_fcts,
  output logic                      o_send_n_chars,
  output logic                      o_send_time_codes,
  output logic                      o_link_reset,
  output logic                      o_char_sequence_error,
  output logic                      o_link_up,
  output logic                      o_link_down
);

  spw_link_pkg::link_state_t state;
  spw_link_pkg::link_state_t state_next;

  // Set when the current event breaks the character sequence rules
  logic seq_error;
  // Any character other than NULL, not allowed before Connecting
  logic got_non_null;
  // Link Enabled guard of the Ready state
  logic link_enabled;

  assign got_non_null = ev.got_fct | ev.got_n_char | ev.got_time_code;

  // Auto start waits for the far end to send a NULL first
  assign link_enabled = ~i_link_disable &
                        (i_link_start | (i_auto_start & ev.got_null));

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  // Receive errors have top priority, then link disable,
  // then sequence errors, then the timeout and last any progress
  always_comb
  begin
    state_next = state;
    seq_error  = 1'b0;
    case (state)
      spw_link_pkg::ERROR_RESET:
      begin
        // Left unconditionally once the short delay has passed
        if (i_after_short)
          state_next = spw_link_pkg::ERROR_WAIT;
      end
      spw_link_pkg::ERROR_WAIT:
      begin
        // Receiver is on here, so a disconnect sends the link back
        if (ev.rx_error)
          state_next = spw_link_pkg::ERROR_RESET;
        else if (i_after_long)
          state_next = spw_link_pkg::READY;
      end
      spw_link_pkg::READY:
      begin
        if (ev.rx_error)
          state_next = spw_link_pkg::ERROR_RESET;
        else if (got_non_null)
        begin
          seq_error  = 1'b1;
          state_next = spw_link_pkg::ERROR_RESET;
        end
        else if (link_enabled)
          state_next = spw_link_pkg::STARTED;
      end
      spw_link_pkg::STARTED:
      begin
        if (ev.rx_error || i_link_disable)
          state_next = spw_link_pkg::ERROR_RESET;
        else if (got_non_null)
        begin
          seq_error  = 1'b1;
          state_next = spw_link_pkg::ERROR_RESET;
        end
        // No NULL seen from the far end within the long delay
        else if (i_after_long)
          state_next = spw_link_pkg::ERROR_RESET;
        else if (ev.got_null)
          state_next = spw_link_pkg::CONNECTING;
      end
      spw_link_pkg::CONNECTING:
      begin
        if (ev.rx_error || i_link_disable)
          state_next = spw_link_pkg::ERROR_RESET;
        // FCTs are now allowed but data characters still are not
        else if (ev.got_n_char)
        begin
          seq_error  = 1'b1;
          state_next = spw_link_pkg::ERROR_RESET;
        end
        else if (i_after_long)
          state_next = spw_link_pkg::ERROR_RESET;
        else if (ev.got_fct)
          state_next = spw_link_pkg::RUN;
      end
      spw_link_pkg::RUN:
      begin
        if (ev.rx_error || i_link_disable)
          state_next = spw_link_pkg::ERROR_RESET;
      end
      default:
      begin
        // Unused encodings fall back to a clean reset of the link
        state_next = spw_link_pkg::ERROR_RESET;
      end
    endcase
  end

  // The timer restarts on the edge that enters a state with a delay
  // so its levels are already low in the first cycle of that state
  assign o_timer_restart = (state_next != state) &&
                           (state_next inside {spw_link_pkg::ERROR_RESET,
                                               spw_link_pkg::ERROR_WAIT,
                                               spw_link_pkg::STARTED,
                                               spw_link_pkg::CONNECTING});

  // ----------------------------------------
  // State register and event pulses
  // ----------------------------------------
  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      state                 <= spw_link_pkg::ERROR_RESET;
      o_char_sequence_error <= 1'b0;
      o_link_up             <= 1'b0;
      o_link_down           <= 1'b0;
    end
    else
    begin
      state                 <= state_next;
      o_char_sequence_error <= seq_error;
      // Link up marks the step from Connecting into Run
      o_link_up             <= (state == spw_link_pkg::CONNECTING) &&
                               (state_next == spw_link_pkg::RUN);
      // Link down marks any exit from Run, whatever the cause
      o_link_down           <= (state == spw_link_pkg::RUN) &&
                               (state_next != spw_link_pkg::RUN);
    end
  end

  // ----------------------------------------
  // Output decode
  // ----------------------------------------
  assign o_link_state      = state;
  assign o_link_reset      = (state == spw_link_pkg::ERROR_RESET);
  // Receiver stays on from ErrorWait upward
  assign o_rx_en           = (state != spw_link_pkg::ERROR_RESET);
  assign o_tx_en           = (state == spw_link_pkg::STARTED) ||
                             (state == spw_link_pkg::CONNECTING) ||
                             (state == spw_link_pkg::RUN);
  assign o_send_nulls      = o_tx_en;
  assign o_send_fcts       = (state == spw_link_pkg::CONNECTING) ||
                             (state == spw_link_pkg::RUN);
  // Data and time codes only once the link is fully up
  assign o_send_n_chars    = (state == spw_link_pkg::RUN);
  assign o_send_time_codes = (state == spw_link_pkg::RUN);

endmodule

//--- spw_link_top.sv
// Module spw_link_top, connects the event synchronizer, delay timer and link FSM
`timescale 1ns/1ns

module spw_link_top #(
  parameter spw_timing_pkg::tick_count_t TICKS_SHORT = spw_timing_pkg::DEFAULT_TICKS_SHORT,
  parameter spw_timing_pkg::tick_count_t TICKS_LONG  = spw_timing_pkg::DEFAULT_TICKS_LONG
) (
  input  logic                                i_clk,
  input  logic                                i_rx_clk,
  input  logic                                i_reset,
  input  logic                                i_link_start,
  input  logic                                i_link_disable,
  input  logic                                i_auto_start,
  input  logic [spw_link_pkg::NUM_EVENTS-1:0] i_rx_events,
  output spw_link_pkg::link_state_t           o_link_state,
  output logic                                o_tx_en,
  output logic                                o_rx_en,
  output logic                                o_send_nulls,
  output logic                                o_send_fcts,
  output logic                                o_send_n_chars,
  output logic                                o_send_time_codes,
  output logic                                o_link_reset,
  output logic                                o_char_sequence_error,
  output logic                                o_link_up,
  output logic                                o_link_down
);

  // Receive events after the crossing into the system clock domain
  spw_rx_event_if rx_ev_if ();

  // Timer handshake between the FSM and the delay counter
  logic timer_restart;
  logic after_short;
  logic after_long;

  // ----------------------------------------
  // Receive event crossing
  // ----------------------------------------
  spw_rx_event_sync spw_rx_event_sync_inst (
    .i_clk       (i_clk),
    .i_rx_clk    (i_rx_clk),
    .i_reset     (i_reset),
    .i_rx_events (i_rx_events),
    .ev          (rx_ev_if.source)
  );

  // ----------------------------------------
  // Short and long delay timer
  // ----------------------------------------
  spw_link_timer #(
    .TICKS_SHORT (TICKS_SHORT),
    .TICKS_LONG  (TICKS_LONG)
  ) spw_link_timer_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_restart     (timer_restart),
    .o_after_short (after_short),
    .o_after_long  (after_long)
  );

  // ----------------------------------------
  // Link state machine
  // ----------------------------------------
  spw_link_fsm spw_link_fsm_inst (
    .i_clk                 (i_clk),
    .i_reset               (i_reset),
    .i_link_start          (i_link_start),
    .i_link_disable        (i_link_disable),
    .i_auto_start          (i_auto_start),
    .ev                    (rx_ev_if.sink),
    .i_after_short         (after_short),
    .i_after_long          (after_long),
    .o_timer_restart       (timer_restart),
    .o_link_state          (o_link_state),
    .o_tx_en               (o_tx_en),
    .o_rx_en               (o_rx_en),
    .o_send_nulls          (o_send_nulls),
    .o_send_fcts           (o_send_fcts),
    .o_send_n_chars        (o_send_n_chars),
    .o_send_time_codes     (o_send_time_codes),
    .o_link_reset          (o_link_reset),
    .o_char_sequence_error (o_char_sequence_error),
    .o_link_up             (o_link_up),
    .o_link_down           (o_link_down)
  );

endmodule

//--- tb_spw_link_top.sv
// Testbench tb_spw_link_top with clocks, stimulus table, compare tasks and cycle timeout
`timescale 1ns/1ns

module tb_spw_link_top;

  // ----------------------------------------
  // Parameters and types
  // ----------------------------------------

  // Short delays keep every step within a few dozen cycles
  localparam spw_timing_pkg::tick_count_t TB_TICKS_SHORT = 16'd8;
  localparam spw_timing_pkg::tick_count_t TB_TICKS_LONG  = 16'd16;
  // Bound for one step to reach its expected state
  localparam int STEP_LIMIT = 2 * int'(TB_TICKS_LONG);
  // Longer than the event crossing, so a wrong move shows up inside this window
  localparam int HOLD_CYCLES = 4;
  localparam logic [31:0] SEED = 32'h3e23_2d00;

  // What one table row does to the DUT
  typedef enum logic [3:0] {
    ACT_WAIT, ACT_START, ACT_AUTO, ACT_DISABLE, ACT_NULL,
    ACT_FCT, ACT_N_CHAR, ACT_TIME_CODE, ACT_RX_ERROR
  } action_t;

  // Which event pulse the row must produce, at most one
  typedef enum logic [1:0] {
    PULSE_NONE, PULSE_SEQ, PULSE_UP, PULSE_DOWN
  } pulse_t;

  typedef struct packed {
    action_t                   act;
    spw_link_pkg::link_state_t state;
    pulse_t                    pulse;
  } step_t;

  // ----------------------------------------
  // DUT signals and instance
  // ----------------------------------------
  logic                                i_clk;
  logic                                i_rx_clk;
  logic                                i_reset;
  logic                                i_link_start;
  logic                                i_link_disable;
  logic                                i_auto_start;
  logic [spw_link_pkg::NUM_EVENTS-1:0] i_rx_events;
  spw_link_pkg::link_state_t           o_link_state;
  logic                                o_tx_en;
  logic                                o_rx_en;
  logic                                o_send_nulls;
  logic                                o_send_fcts;
  logic                                o_send_n_chars;
  logic                                o_send_time_codes;
  logic                                o_link_reset;
  logic                                o_char_sequence_error;
  logic                                o_link_up;
  logic                                o_link_down;

  step_t steps[$];
  // Pulses seen during the current step
  int    seq_count     = 0;
  int    up_count      = 0;
  int    down_count    = 0;
  int    cycle_count   = 0;
  int    timeout_limit = 0;

  spw_link_top #(
    .TICKS_SHORT (TB_TICKS_SHORT),
    .TICKS_LONG  (TB_TICKS_LONG)
  ) spw_link_top_inst (
    .i_clk                 (i_clk),
    .i_rx_clk              (i_rx_clk),
    .i_reset               (i_reset),
    .i_link_start          (i_link_start),
    .i_link_disable        (i_link_disable),
    .i_auto_start          (i_auto_start),
    .i_rx_events           (i_rx_events),
    .o_link_state          (o_link_state),
    .o_tx_en               (o_tx_en),
    .o_rx_en               (o_rx_en),
    .o_send_nulls          (o_send_nulls),
    .o_send_fcts           (o_send_fcts),
    .o_send_n_chars        (o_send_n_chars),
    .o_send_time_codes     (o_send_time_codes),
    .o_link_reset          (o_link_reset),
    .o_char_sequence_error (o_char_sequence_error),
    .o_link_up             (o_link_up),
    .o_link_down           (o_link_down)
  );

  // System clock at 4 ns and an unrelated receive clock at 6 ns
  always #2 i_clk = ~i_clk;
  always #3 i_rx_clk = ~i_rx_clk;

  // Cycle budget scales with the number of table rows
  always @(posedge i_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit)
      stop_on_error("timeout, the link did not finish the table within its cycle budget");
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_state(input spw_link_pkg::link_state_t got,
                             input spw_link_pkg::link_state_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: o_link_state got %s expected %s",
                              $time, got.name(), exp.name()));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s got %b expected %b",
                              $time, name, got, exp));
  endtask

  task automatic check_pulse(input string name, input int got, input int exp);
    if (got != exp)
      stop_on_error($sformatf("mismatch at %0t ns: %s pulse count got %0d expected %0d",
                              $time, name, got, exp));
  endtask

  // Decode rule for enables and send levels, applied to the state shown
  task automatic check_outputs(input spw_link_pkg::link_state_t st);
    logic tx_on;
    logic fct_on;
    tx_on  = st inside {spw_link_pkg::STARTED, spw_link_pkg::CONNECTING,
                        spw_link_pkg::RUN};
    fct_on = st inside {spw_link_pkg::CONNECTING, spw_link_pkg::RUN};
    check_level("o_link_reset", o_link_reset, st == spw_link_pkg::ERROR_RESET);
    check_level("o_rx_en", o_rx_en, st != spw_link_pkg::ERROR_RESET);
    check_level("o_tx_en", o_tx_en, tx_on);
    check_level("o_send_nulls", o_send_nulls, tx_on);
    check_level("o_send_fcts", o_send_fcts, fct_on);
    check_level("o_send_n_chars", o_send_n_chars, st == spw_link_pkg::RUN);
    check_level("o_send_time_codes", o_send_time_codes, st == spw_link_pkg::RUN);
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // Outputs are stable at the falling edge, which is also where inputs change
  task automatic sample_cycle();
    @(negedge i_clk);
    if (o_char_sequence_error)
      seq_count++;
    if (o_link_up)
      up_count++;
    if (o_link_down)
      down_count++;
    check_outputs(o_link_state);
  endtask

  // One receive clock wide pulse, launched on the falling receive edge
  task automatic send_event(input logic [spw_link_pkg::NUM_EVENTS-1:0] mask);
    @(negedge i_rx_clk);
    i_rx_events = mask;
    @(negedge i_rx_clk);
    i_rx_events = '0;
  endtask

  task automatic apply_action(input action_t act);
    case (act)
      ACT_START:
      begin
        i_link_disable = 1'b0;
        i_link_start   = 1'b1;
      end
      ACT_AUTO:
      begin
        i_link_disable = 1'b0;
        i_auto_start   = 1'b1;
      end
      ACT_DISABLE:
      begin
        i_link_start   = 1'b0;
        i_auto_start   = 1'b0;
        i_link_disable = 1'b1;
      end
      ACT_NULL:      send_event(5'd1 << spw_link_pkg::EV_NULL);
      ACT_FCT:       send_event(5'd1 << spw_link_pkg::EV_FCT);
      ACT_N_CHAR:    send_event(5'd1 << spw_link_pkg::EV_N_CHAR);
      ACT_TIME_CODE: send_event(5'd1 << spw_link_pkg::EV_TIME_CODE);
      ACT_RX_ERROR:  send_event(5'd1 << spw_link_pkg::EV_RX_ERROR);
      default:
      begin
        // A wait row only lets the delays run
      end
    endcase
  endtask

  task automatic wait_for_state(input spw_link_pkg::link_state_t exp);
    int n;
    n = 0;
    while (o_link_state !== exp)
    begin
      if (n >= STEP_LIMIT)
        stop_on_error($sformatf("link never reached %s within %0d cycles",
                                exp.name(), STEP_LIMIT));
      sample_cycle();
      n++;
    end
  endtask

  // The link must stay in the given state for every cycle of the window
  task automatic hold_state(input spw_link_pkg::link_state_t exp);
    repeat (HOLD_CYCLES)
    begin
      sample_cycle();
      check_state(o_link_state, exp);
    end
  endtask

  task automatic run_step(input step_t s);
    int   idle;
    logic hold;
    seq_count  = 0;
    up_count   = 0;
    down_count = 0;
    // Random idle moves each event to a new phase of the receive clock
    idle = $urandom_range(2, 0);
    repeat (idle) sample_cycle();
    // A row that expects no change of state is watched for a while instead
    hold = (o_link_state === s.state);
    apply_action(s.act);
    if (hold)
      hold_state(s.state);
    else
      wait_for_state(s.state);
    // Start and disable are commands, held only until the step is done
    i_link_start   = 1'b0;
    i_link_disable = 1'b0;
    check_pulse("o_char_sequence_error", seq_count, (s.pulse == PULSE_SEQ) ? 1 : 0);
    check_pulse("o_link_up", up_count, (s.pulse == PULSE_UP) ? 1 : 0);
    check_pulse("o_link_down", down_count, (s.pulse == PULSE_DOWN) ? 1 : 0);
  endtask

  task automatic add_step(input action_t act, input spw_link_pkg::link_state_t st,
                          input pulse_t pl);
    steps.push_back('{act, st, pl});
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_table();
    // Walk up to Ready on the delays alone, then a full start to Run
    add_step(ACT_WAIT,      spw_link_pkg::ERROR_WAIT,  PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_START,     spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::CONNECTING,  PULSE_NONE);
    add_step(ACT_FCT,       spw_link_pkg::RUN,         PULSE_UP);
    add_step(ACT_DISABLE,   spw_link_pkg::ERROR_RESET, PULSE_DOWN);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    // Auto start stays on from here and lets a NULL start the link
    add_step(ACT_AUTO,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::CONNECTING,  PULSE_NONE);
    add_step(ACT_N_CHAR,    spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    // Characters other than NULL are sequence errors in Ready
    add_step(ACT_FCT,       spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_N_CHAR,    spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_TIME_CODE, spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    // Same rule in Started
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_FCT,       spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_N_CHAR,    spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_TIME_CODE, spw_link_pkg::ERROR_RESET, PULSE_SEQ);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    // No progress in Started or Connecting times out after the long delay
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::ERROR_RESET, PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::CONNECTING,  PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::ERROR_RESET, PULSE_NONE);
    // Receive errors from ErrorWait upward, with no sequence error
    add_step(ACT_WAIT,      spw_link_pkg::ERROR_WAIT,  PULSE_NONE);
    add_step(ACT_RX_ERROR,  spw_link_pkg::ERROR_RESET, PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_RX_ERROR,  spw_link_pkg::ERROR_RESET, PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_RX_ERROR,  spw_link_pkg::ERROR_RESET, PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::CONNECTING,  PULSE_NONE);
    add_step(ACT_RX_ERROR,  spw_link_pkg::ERROR_RESET, PULSE_NONE);
    add_step(ACT_WAIT,      spw_link_pkg::READY,       PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::STARTED,     PULSE_NONE);
    add_step(ACT_NULL,      spw_link_pkg::CONNECTING,  PULSE_NONE);
    add_step(ACT_FCT,       spw_link_pkg::RUN,         PULSE_UP);
    // Leaving Run for any reason marks the link as down
    add_step(ACT_RX_ERROR,  spw_link_pkg::ERROR_RESET, PULSE_DOWN);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    i_clk          = 1'b0;
    i_rx_clk       = 1'b0;
    i_reset        = 1'b1;
    i_link_start   = 1'b0;
    i_link_disable = 1'b0;
    i_auto_start   = 1'b0;
    i_rx_events    = '0;
    void'($urandom(SEED));
    build_table();
    timeout_limit = (steps.size() + 1) * STEP_LIMIT;

    repeat (5) @(negedge i_clk);
    i_reset = 1'b0;

    // Reset leaves the link in ErrorReset with every pulse low
    sample_cycle();
    check_state(o_link_state, spw_link_pkg::ERROR_RESET);
    check_pulse("o_char_sequence_error", seq_count, 0);
    check_pulse("o_link_up", up_count, 0);
    check_pulse("o_link_down", down_count, 0);

    for (int i = 0; i < steps.size(); i++)
      run_step(steps[i]);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- verilog.f
spw_link_pkg.sv
spw_timing_pkg.sv
spw_rx_event_if.sv
spw_rx_event_sync.sv
spw_link_timer.sv
spw_link_fsm.sv
spw_link_top.sv
tb_spw_link_top.sv

//--- Makefile
# Verilator build and run of the SpaceWire link controller testbench

VERILATOR ?= verilator
TOP       ?= tb_spw_link_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
